//--- source/awg_pkg.sv
// shared types for awg_lite; at most 8 channels and MAX_DEPTH batches per channel
package awg_pkg;

  localparam int SAMPLE_WIDTH = 16;
  localparam int PARALLEL_SAMPLES = 2;
  localparam int MAX_DEPTH = 64;
  localparam int ADDR_W = $clog2(MAX_DEPTH);
  // one extra bit so a completely full channel can be described
  localparam int DEPTH_W = ADDR_W + 1;
  localparam int BURST_W = 16;
  localparam int CHAN_W = 3;

  // lowest sample sits in the low bits
  typedef logic [PARALLEL_SAMPLES-1:0][SAMPLE_WIDTH-1:0] sample_batch_t;

  typedef enum logic [1:0] {
    TRIG_NONE  = 2'd0,
    TRIG_FIRST = 2'd1,
    TRIG_EVERY = 2'd2
  } trig_mode_e;

  typedef enum logic [1:0] {
    XFER_OK           = 2'd0,
    XFER_EARLY_LAST   = 2'd1,
    XFER_MISSING_LAST = 2'd2
  } xfer_error_e;

  typedef struct packed {
    logic [DEPTH_W-1:0] depth;
    logic [BURST_W-1:0] burst;
    trig_mode_e         trig;
  } chan_config_t;

  typedef struct packed {
    logic              en;
    logic [CHAN_W-1:0] chan;
    logic [ADDR_W-1:0] addr;
    sample_batch_t     data;
  } mem_write_t;

endpackage

//--- source/awg_config_regs.sv
// config registers; readies are registered, so they rise one cycle after busy falls
`timescale 1ns/1ps

module awg_config_regs import awg_pkg::*; #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 64
) (
  input  logic                        dma_clk,
  input  logic                        rst_n,
  input  logic                        trig_valid,
  input  logic [2*CHANNELS-1:0]       trig_data,
  output logic                        trig_ready,
  input  logic                        burst_valid,
  input  logic [BURST_W*CHANNELS-1:0] burst_data,
  output logic                        burst_ready,
  input  logic                        depth_valid,
  input  logic [DEPTH_W*CHANNELS-1:0] depth_data,
  output logic                        depth_ready,
  input  logic                        busy,
  output chan_config_t                chan_cfg [CHANNELS],
  output logic                        arm
);

  logic cfg_ready;
  logic [DEPTH_W-1:0] depth_in [CHANNELS];

  assign trig_ready = cfg_ready;
  assign burst_ready = cfg_ready;
  assign depth_ready = cfg_ready;
  assign arm = depth_valid & cfg_ready;

  // depths beyond the memory size are clamped to the memory size
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      if (depth_data[c*DEPTH_W +: DEPTH_W] > DEPTH_W'(DEPTH)) begin
        depth_in[c] = DEPTH_W'(DEPTH);
      end else begin
        depth_in[c] = depth_data[c*DEPTH_W +: DEPTH_W];
      end
    end
  end

  // arm also drops ready so no write sneaks in before loading is visible
  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_ready <= 1'b0;
    end else begin
      cfg_ready <= ~(busy | arm);
    end
  end

  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < CHANNELS; c++) begin
        chan_cfg[c] <= '{depth: '0, burst: '0, trig: TRIG_NONE};
      end
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (trig_valid && cfg_ready) begin
          chan_cfg[c].trig <= trig_mode_e'(trig_data[2*c +: 2]);
        end
        if (burst_valid && cfg_ready) begin
          chan_cfg[c].burst <= burst_data[c*BURST_W +: BURST_W];
        end
        if (arm) begin
          chan_cfg[c].depth <= depth_in[c];
        end
      end
    end
  end

endmodule

//--- source/awg_dma_loader.sv
// dma loader; a depth write with every channel at 0 ends at once with XFER_OK
`timescale 1ns/1ps

module awg_dma_loader import awg_pkg::*; #(
  parameter int CHANNELS = 2
) (
  input  logic          dma_clk,
  input  logic          rst_n,
  input  logic          arm,
  input  chan_config_t  chan_cfg [CHANNELS],
  input  logic          dma_valid,
  input  sample_batch_t dma_data,
  input  logic          dma_last,
  output logic          dma_ready,
  output mem_write_t    mem_wr,
  output logic          loading,
  output logic          err_valid,
  output xfer_error_e   err_code,
  input  logic          err_ready
);

  logic [CHAN_W-1:0]  chan;
  logic [ADDR_W-1:0]  addr;
  logic [CHAN_W-1:0]  eff_chan;
  logic [DEPTH_W-1:0] eff_depth;
  logic               found;
  logic               more;
  logic               beat;
  logic               chan_end;
  logic               is_final;
  xfer_error_e        end_code;

  // first non-empty channel at or above chan, and whether another one follows
  always_comb begin
    found = 1'b0;
    more = 1'b0;
    eff_chan = '0;
    eff_depth = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      if (c >= chan && chan_cfg[c].depth != '0) begin
        if (!found) begin
          found = 1'b1;
          eff_chan = CHAN_W'(c);
          eff_depth = chan_cfg[c].depth;
        end else begin
          more = 1'b1;
        end
      end
    end
  end

  assign dma_ready = loading & found;
  assign beat = dma_valid & dma_ready;
  assign chan_end = {1'b0, addr} == eff_depth - 1'b1;
  assign is_final = chan_end & ~more;

  always_comb begin
    if (is_final && dma_last) begin
      end_code = XFER_OK;
    end else if (dma_last) begin
      end_code = XFER_EARLY_LAST;
    end else begin
      end_code = XFER_MISSING_LAST;
    end
  end

  assign mem_wr = '{en: beat, chan: eff_chan, addr: addr, data: dma_data};

  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      loading <= 1'b0;
      chan <= '0;
      addr <= '0;
      err_valid <= 1'b0;
      err_code <= XFER_OK;
    end else begin
      if (err_valid && err_ready) begin
        err_valid <= 1'b0;
      end
      if (arm) begin
        loading <= 1'b1;
        chan <= '0;
        addr <= '0;
      end else if (loading && !found) begin
        loading <= 1'b0;
        err_valid <= 1'b1;
        err_code <= XFER_OK;
      end else if (beat) begin
        if (dma_last || is_final) begin
          loading <= 1'b0;
          err_valid <= 1'b1;
          err_code <= end_code;
        end else if (chan_end) begin
          chan <= eff_chan + 1'b1;
          addr <= '0;
        end else begin
          addr <= addr + 1'b1;
        end
      end
    end
  end

endmodule

//--- source/awg_wave_memory.sv
// waveform storage, contents undefined after power-up; addresses must stay below DEPTH
`timescale 1ns/1ps

module awg_wave_memory import awg_pkg::*; #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 64
) (
  input  logic          dma_clk,
  input  mem_write_t    mem_wr,
  input  logic [ADDR_W-1:0] rd_addr [CHANNELS],
  output sample_batch_t rd_data [CHANNELS]
);

  for (genvar c = 0; c < CHANNELS; c++) begin : g_chan
    sample_batch_t mem [DEPTH];
    logic          wr_hit;

    assign wr_hit = mem_wr.en && (mem_wr.chan == CHAN_W'(c));

    always_ff @(posedge dma_clk) begin
      if (wr_hit) begin
        mem[mem_wr.addr] <= mem_wr.data;
      end
    end

    // registered read, data follows the address by one cycle
    always_ff @(posedge dma_clk) begin
      rd_data[c] <= mem[rd_addr[c]];
    end
  end

endmodule

//--- source/awg_channel_player.sv
// one playback channel; cfg must not change while the channel is active
`timescale 1ns/1ps

module awg_channel_player import awg_pkg::*; (
  input  logic              dma_clk,
  input  logic              rst_n,
  input  chan_config_t      cfg,
  input  logic              start,
  input  logic              stop,
  output logic [ADDR_W-1:0] rd_addr,
  input  sample_batch_t     rd_data,
  output logic              active,
  output sample_batch_t     out_data,
  output logic              out_valid,
  output logic              out_trigger
);

  logic [ADDR_W-1:0]  addr;
  logic [BURST_W-1:0] burst_cnt;
  logic               valid_d;
  logic               trig_d;
  logic               trig_now;
  logic               last_addr;
  logic               last_burst;

  assign rd_addr = addr;
  assign last_addr = {1'b0, addr} == cfg.depth - 1'b1;
  assign last_burst = burst_cnt == cfg.burst - 1'b1;

  always_comb begin
    trig_now = 1'b0;
    if (addr == '0) begin
      case (cfg.trig)
        TRIG_FIRST: trig_now = burst_cnt == '0;
        TRIG_EVERY: trig_now = 1'b1;
        default:    trig_now = 1'b0;
      endcase
    end
  end

  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      addr <= '0;
      burst_cnt <= '0;
      valid_d <= 1'b0;
      trig_d <= 1'b0;
    end else begin
      // valid and trigger line up with the registered memory read
      valid_d <= active & ~stop;
      trig_d <= active & ~stop & trig_now;
      if (stop) begin
        active <= 1'b0;
      end else if (start) begin
        active <= (cfg.depth != '0) && (cfg.burst != '0);
        addr <= '0;
        burst_cnt <= '0;
      end else if (active) begin
        if (last_addr) begin
          addr <= '0;
          if (last_burst) begin
            active <= 1'b0;
          end else begin
            burst_cnt <= burst_cnt + 1'b1;
          end
        end else begin
          addr <= addr + 1'b1;
        end
      end
    end
  end

  assign out_valid = valid_d;
  assign out_trigger = trig_d;
  assign out_data = valid_d ? rd_data : '0;

endmodule

//--- source/awg_top.sv
// awg_lite top; CHANNELS at most 8, DEPTH at most MAX_DEPTH, larger depth writes are clamped
`timescale 1ns/1ps

module awg_top import awg_pkg::*; #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 64
) (
  input  logic                        dma_clk,
  input  logic                        rst_n,
  input  logic                        trig_cfg_valid,
  output logic                        trig_cfg_ready,
  input  logic [2*CHANNELS-1:0]       trig_cfg_data,
  input  logic                        burst_cfg_valid,
  output logic                        burst_cfg_ready,
  input  logic [BURST_W*CHANNELS-1:0] burst_cfg_data,
  input  logic                        depth_cfg_valid,
  output logic                        depth_cfg_ready,
  input  logic [DEPTH_W*CHANNELS-1:0] depth_cfg_data,
  input  logic                        dma_in_valid,
  output logic                        dma_in_ready,
  input  sample_batch_t               dma_in_data,
  input  logic                        dma_in_last,
  input  logic                        start_stop_valid,
  output logic                        start_stop_ready,
  input  logic [1:0]                  start_stop_data,
  output logic                        xfer_error_valid,
  input  logic                        xfer_error_ready,
  output xfer_error_e                 xfer_error_data,
  output sample_batch_t               dac_data [CHANNELS],
  output logic [CHANNELS-1:0]         dac_valid,
  output logic [CHANNELS-1:0]         dac_trigger
);

  chan_config_t      chan_cfg [CHANNELS];
  mem_write_t        mem_wr;
  logic [ADDR_W-1:0] rd_addr [CHANNELS];
  sample_batch_t     rd_data [CHANNELS];
  logic [CHANNELS-1:0] chan_active;
  logic              arm;
  logic              loading;
  logic              ss_enable;
  logic              ss_beat;
  logic              start_pulse;
  logic              stop_pulse;
  logic              busy;

  // holds start/stop ready low until the first clock after reset
  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      ss_enable <= 1'b0;
    end else begin
      ss_enable <= 1'b1;
    end
  end

  // bit 1 is start, bit 0 is stop; start waits while a load is pending
  assign start_stop_ready = ss_enable & (~(loading | arm) | start_stop_data[0]);
  assign ss_beat = start_stop_valid & start_stop_ready;
  assign start_pulse = ss_beat & start_stop_data[1] & ~(loading | arm);
  assign stop_pulse = ss_beat & start_stop_data[0];
  assign busy = loading | (|chan_active) | start_pulse;

  awg_config_regs #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) awg_config_regs_inst (
    .dma_clk, .rst_n,
    .trig_valid(trig_cfg_valid), .trig_data(trig_cfg_data), .trig_ready(trig_cfg_ready),
    .burst_valid(burst_cfg_valid), .burst_data(burst_cfg_data),
    .burst_ready(burst_cfg_ready),
    .depth_valid(depth_cfg_valid), .depth_data(depth_cfg_data),
    .depth_ready(depth_cfg_ready),
    .busy, .chan_cfg, .arm
  );

  awg_dma_loader #(.CHANNELS(CHANNELS)) awg_dma_loader_inst (
    .dma_clk, .rst_n, .arm, .chan_cfg,
    .dma_valid(dma_in_valid), .dma_data(dma_in_data), .dma_last(dma_in_last),
    .dma_ready(dma_in_ready), .mem_wr, .loading,
    .err_valid(xfer_error_valid), .err_code(xfer_error_data),
    .err_ready(xfer_error_ready)
  );

  awg_wave_memory #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) awg_wave_memory_inst (
    .dma_clk, .mem_wr, .rd_addr, .rd_data
  );

  for (genvar c = 0; c < CHANNELS; c++) begin : g_player
    awg_channel_player awg_channel_player_inst (
      .dma_clk, .rst_n,
      .cfg(chan_cfg[c]), .start(start_pulse), .stop(stop_pulse),
      .rd_addr(rd_addr[c]), .rd_data(rd_data[c]), .active(chan_active[c]),
      .out_data(dac_data[c]), .out_valid(dac_valid[c]), .out_trigger(dac_trigger[c])
    );
  end

endmodule

//--- bench/awg_clock_gen.sv
// testbench clock and reset; reset is released 1 ns after the edge that ends it
`timescale 1ns/1ps

module awg_clock_gen #(
  parameter int HALF_PERIOD_NS = 2,
  parameter int RESET_CYCLES = 10
) (
  output logic dma_clk,
  output logic rst_n
);

  initial begin
    dma_clk = 1'b0;
    forever #(HALF_PERIOD_NS) dma_clk = ~dma_clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge dma_clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

//--- bench/awg_assertions.sv
// stream checks bound into awg_top; all properties are disabled while rst_n is low
`timescale 1ns/1ps

module awg_assertions import awg_pkg::*; #(
  parameter int CHANNELS = 2
) (
  input logic                dma_clk,
  input logic                rst_n,
  input logic [CHANNELS-1:0] dac_valid,
  input logic [CHANNELS-1:0] dac_trigger,
  input logic                xfer_error_valid,
  input logic                xfer_error_ready,
  input xfer_error_e         xfer_error_data,
  input logic                trig_cfg_ready,
  input logic                burst_cfg_ready,
  input logic                depth_cfg_ready,
  input logic                loading
);

  int unsigned fail_count = 0;

  a_trigger_with_valid: assert property (@(posedge dma_clk) disable iff (!rst_n)
    (dac_trigger & ~dac_valid) == '0)
    else begin
      $error("dac_trigger high on a channel without dac_valid");
      fail_count++;
    end

  // the error code must wait for its reader
  a_error_held: assert property (@(posedge dma_clk) disable iff (!rst_n)
    xfer_error_valid && !xfer_error_ready |=> xfer_error_valid && $stable(xfer_error_data))
    else begin
      $error("xfer_error dropped or changed before it was read");
      fail_count++;
    end

  a_no_cfg_while_loading: assert property (@(posedge dma_clk) disable iff (!rst_n)
    loading |-> !(trig_cfg_ready || burst_cfg_ready || depth_cfg_ready))
    else begin
      $error("config ready high while the loader is busy");
      fail_count++;
    end

endmodule

bind awg_top awg_assertions #(.CHANNELS(CHANNELS)) awg_assertions_inst (
  .dma_clk, .rst_n, .dac_valid, .dac_trigger,
  .xfer_error_valid, .xfer_error_ready, .xfer_error_data,
  .trig_cfg_ready, .burst_cfg_ready, .depth_cfg_ready, .loading
);

//--- bench/awg_tb.sv
// awg_lite testbench for 2 channels; a trial with an early or missing last is not played
`timescale 1ns/1ps

module awg_tb import awg_pkg::*; ();

  localparam int CHANNELS = 2;
  localparam int DEPTH = 64;
  localparam int NUM_TRIALS = 7;
  localparam logic [1:0] LAST_OK = 2'd0;
  localparam logic [1:0] LAST_EARLY = 2'd1;
  localparam logic [1:0] LAST_MISSING = 2'd2;

  typedef struct packed {
    logic [CHANNELS-1:0][DEPTH_W-1:0] depth;
    logic [CHANNELS-1:0][BURST_W-1:0] burst;
    logic [CHANNELS-1:0][1:0]         trig;
    logic [1:0]                       last_mode;
    logic [7:0]                       stop_at;
  } trial_t;

  // channel 1 comes first in each concatenation; stop_at 0 means play to the end
  localparam trial_t TRIALS [NUM_TRIALS] = '{
    '{depth: {7'd3, 7'd4}, burst: {16'd2, 16'd3}, trig: {TRIG_EVERY, TRIG_FIRST},
      last_mode: LAST_OK, stop_at: 8'd0},
    '{depth: {7'd5, 7'd2}, burst: {16'd1, 16'd4}, trig: {TRIG_NONE, TRIG_EVERY},
      last_mode: LAST_EARLY, stop_at: 8'd0},
    '{depth: {7'd2, 7'd6}, burst: {16'd3, 16'd1}, trig: {TRIG_FIRST, TRIG_NONE},
      last_mode: LAST_MISSING, stop_at: 8'd0},
    '{depth: {7'd0, 7'd5}, burst: {16'd2, 16'd2}, trig: {TRIG_EVERY, TRIG_EVERY},
      last_mode: LAST_OK, stop_at: 8'd0},
    '{depth: {7'd6, 7'd8}, burst: {16'd4, 16'd5}, trig: {TRIG_FIRST, TRIG_EVERY},
      last_mode: LAST_OK, stop_at: 8'd10},
    '{depth: {7'd3, 7'd2}, burst: {16'd0, 16'd2}, trig: {TRIG_EVERY, TRIG_FIRST},
      last_mode: LAST_OK, stop_at: 8'd0},
    '{depth: {7'd16, 7'd12}, burst: {16'd2, 16'd3}, trig: {TRIG_NONE, TRIG_FIRST},
      last_mode: LAST_OK, stop_at: 8'd0}
  };

  logic dma_clk;
  logic rst_n;
  logic trig_cfg_valid, trig_cfg_ready;
  logic [2*CHANNELS-1:0] trig_cfg_data;
  logic burst_cfg_valid, burst_cfg_ready;
  logic [BURST_W*CHANNELS-1:0] burst_cfg_data;
  logic depth_cfg_valid, depth_cfg_ready;
  logic [DEPTH_W*CHANNELS-1:0] depth_cfg_data;
  logic dma_in_valid, dma_in_ready, dma_in_last;
  sample_batch_t dma_in_data;
  logic start_stop_valid, start_stop_ready;
  logic [1:0] start_stop_data;
  logic xfer_error_valid, xfer_error_ready;
  xfer_error_e xfer_error_data;
  sample_batch_t dac_data [CHANNELS];
  logic [CHANNELS-1:0] dac_valid, dac_trigger;
  logic [15:0] lfsr_state;
  sample_batch_t ref_mem [CHANNELS][DEPTH];

  awg_clock_gen awg_clock_gen_inst (.dma_clk, .rst_n);

  awg_top #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) awg_top_inst (.*);

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      $display("tests failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_sample(output logic [SAMPLE_WIDTH-1:0] s);
    s = '0;
    for (int b = 0; b < SAMPLE_WIDTH; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      s = {s[SAMPLE_WIDTH-2:0], lfsr_state[0]};
    end
    // a zero sample would look like idle output
    if (s == '0) begin
      s = 1;
    end
  endtask

  task automatic next_edge();
    @(posedge dma_clk);
    #1;
  endtask

  task automatic write_config(input trial_t t);
    next_edge();
    trig_cfg_valid = 1'b1;
    trig_cfg_data = t.trig;
    burst_cfg_valid = 1'b1;
    burst_cfg_data = t.burst;
    @(negedge dma_clk);
    while (!trig_cfg_ready) @(negedge dma_clk);
    check_value("burst_cfg_ready", burst_cfg_ready, 1'b1);
    next_edge();
    trig_cfg_valid = 1'b0;
    burst_cfg_valid = 1'b0;
    depth_cfg_valid = 1'b1;
    depth_cfg_data = t.depth;
    @(negedge dma_clk);
    while (!depth_cfg_ready) @(negedge dma_clk);
    next_edge();
    depth_cfg_valid = 1'b0;
  endtask

  // words fill channel 0 first, then channel 1
  task automatic load_words(input trial_t t);
    int count;
    int chan;
    int addr;
    logic [SAMPLE_WIDTH-1:0] s0, s1;
    count = t.depth[0] + t.depth[1];
    if (t.last_mode == LAST_EARLY) begin
      count = count / 2;
    end
    for (int k = 0; k < count; k++) begin
      draw_sample(s0);
      draw_sample(s1);
      chan = (k < t.depth[0]) ? 0 : 1;
      addr = (chan == 0) ? k : k - t.depth[0];
      ref_mem[chan][addr] = {s1, s0};
      dma_in_valid = 1'b1;
      dma_in_data = {s1, s0};
      dma_in_last = (t.last_mode != LAST_MISSING) && (k == count - 1);
      @(negedge dma_clk);
      check_value("dma_in_ready", dma_in_ready, 1'b1);
      next_edge();
    end
    dma_in_valid = 1'b0;
    dma_in_last = 1'b0;
  endtask

  task automatic read_error(input xfer_error_e exp_code);
    @(negedge dma_clk);
    check_value("dma_in_ready", dma_in_ready, 1'b0);
    repeat (3) begin
      check_value("xfer_error_valid", xfer_error_valid, 1'b1);
      check_value("xfer_error_data", xfer_error_data, exp_code);
      @(negedge dma_clk);
    end
    next_edge();
    xfer_error_ready = 1'b1;
    next_edge();
    xfer_error_ready = 1'b0;
    @(negedge dma_clk);
    check_value("xfer_error_valid", xfer_error_valid, 1'b0);
  endtask

  task automatic play_and_check(input trial_t t);
    int len [CHANNELS];
    int span;
    int i;
    int a;
    logic exp_valid;
    logic exp_trig;
    sample_batch_t exp_data;
    span = 0;
    for (int c = 0; c < CHANNELS; c++) begin
      len[c] = t.depth[c] * t.burst[c];
      span = (len[c] > span) ? len[c] : span;
    end
    next_edge();
    start_stop_valid = 1'b1;
    start_stop_data = 2'b10;
    @(negedge dma_clk);
    while (!start_stop_ready) @(negedge dma_clk);
    next_edge();
    start_stop_valid = 1'b0;
    // tc 0 is the cycle right after the start beat, batch i shows at tc i+1
    for (int tc = 0; tc <= span + 2; tc++) begin
      @(negedge dma_clk);
      i = tc - 1;
      for (int c = 0; c < CHANNELS; c++) begin
        exp_valid = (i >= 0) && (i < len[c]) && (t.stop_at == 0 || tc <= t.stop_at + 1);
        a = exp_valid ? i % t.depth[c] : 0;
        exp_data = exp_valid ? ref_mem[c][a] : '0;
        exp_trig = exp_valid && (a == 0) && ((t.trig[c] == TRIG_EVERY) ||
                   (t.trig[c] == TRIG_FIRST && i < t.depth[c]));
        check_value($sformatf("dac_valid[%0d]", c), dac_valid[c], exp_valid);
        check_value($sformatf("dac_data[%0d]", c), dac_data[c], exp_data);
        check_value($sformatf("dac_trigger[%0d]", c), dac_trigger[c], exp_trig);
      end
      if (t.stop_at != 0 && tc == t.stop_at) begin
        next_edge();
        start_stop_valid = 1'b1;
        start_stop_data = 2'b01;
      end else if (t.stop_at != 0 && tc == t.stop_at + 1) begin
        next_edge();
        start_stop_valid = 1'b0;
      end
    end
  endtask

  function automatic int unsigned budget_cycles();
    int unsigned total;
    total = 100;
    for (int r = 0; r < NUM_TRIALS; r++) begin
      total += 50;
      for (int c = 0; c < CHANNELS; c++) begin
        total += TRIALS[r].depth[c] + TRIALS[r].depth[c] * TRIALS[r].burst[c];
      end
    end
    return total * 2;
  endfunction

  initial begin : stimulus
    xfer_error_e exp_code;
    trig_cfg_valid = 1'b0;
    trig_cfg_data = '0;
    burst_cfg_valid = 1'b0;
    burst_cfg_data = '0;
    depth_cfg_valid = 1'b0;
    depth_cfg_data = '0;
    dma_in_valid = 1'b0;
    dma_in_data = '0;
    dma_in_last = 1'b0;
    start_stop_valid = 1'b0;
    start_stop_data = '0;
    xfer_error_ready = 1'b0;
    lfsr_state = 16'd46;
    // outputs while reset is still asserted
    repeat (3) @(negedge dma_clk);
    check_value("trig_cfg_ready", trig_cfg_ready, 1'b0);
    check_value("burst_cfg_ready", burst_cfg_ready, 1'b0);
    check_value("depth_cfg_ready", depth_cfg_ready, 1'b0);
    check_value("dma_in_ready", dma_in_ready, 1'b0);
    check_value("start_stop_ready", start_stop_ready, 1'b0);
    check_value("xfer_error_valid", xfer_error_valid, 1'b0);
    check_value("dac_valid", dac_valid, '0);
    check_value("dac_trigger", dac_trigger, '0);
    while (rst_n !== 1'b1) @(posedge dma_clk);
    for (int r = 0; r < NUM_TRIALS; r++) begin
      write_config(TRIALS[r]);
      load_words(TRIALS[r]);
      exp_code = (TRIALS[r].last_mode == LAST_EARLY) ? XFER_EARLY_LAST :
                 (TRIALS[r].last_mode == LAST_MISSING) ? XFER_MISSING_LAST : XFER_OK;
      read_error(exp_code);
      if (TRIALS[r].last_mode == LAST_OK) begin
        play_and_check(TRIALS[r]);
      end
    end
    $display("all tests passed");
    $finish;
  end

  initial begin : assertion_watch
    wait (awg_top_inst.awg_assertions_inst.fail_count != 0);
    $display("error: a bound assertion on awg_top failed");
    $display("tests failed");
    $fatal(1, "assertion failure");
  end

  initial begin : watchdog
    int unsigned limit;
    limit = budget_cycles();
    repeat (limit) @(posedge dma_clk);
    $display("error: watchdog expired after %0d cycles, the DUT stopped responding", limit);
    $display("tests failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

//--- awg_lite.f
source/awg_pkg.sv
source/awg_config_regs.sv
source/awg_dma_loader.sv
source/awg_wave_memory.sv
source/awg_channel_player.sv
source/awg_top.sv
bench/awg_clock_gen.sv
bench/awg_assertions.sv
bench/awg_tb.sv

//--- run_sim.sh
#!/bin/sh
# compiles and runs the awg_lite testbench with Verilator, exits non-zero on failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module awg_tb \
  -f awg_lite.f -o awg_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/awg_sim +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  echo "result: PASS"
  exit 0
fi
echo "result: FAIL"
exit 1
